/* Bender.yml */
package:
  name: ex_block

sources:
  - files:
      - rtl/ex_pkg.sv
      - rtl/alu_share_if.sv
      - rtl/ex_alu.sv
      - rtl/ex_multdiv_slow.sv
      - rtl/ex_block.sv
  - target: test
    files:
      - bench/ex_block_assertions.sv
      - bench/tb_ex_block.sv

/* bench/ex_block_assertions.sv */
// Concurrent checks on the execute stage top
// Valid known and high for ALU ops, stable under back-pressure, register write

`timescale 1ns/100ps

module ex_block_assertions
  import ex_pkg::*;
(
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            md_sel_i,
  input logic            ready_i,
  input logic            ex_valid_i,
  input logic [XLEN-1:0] result_i,
  input logic            imd_val_we_i
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(ex_valid_i))
    else begin
      fail_count++;
      $error("ex_valid_o is unknown");
    end

  alu_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !md_sel_i |-> ex_valid_i)
    else begin
      fail_count++;
      $error("ex_valid_o low while md_sel_i is low");
    end

  // Finish state holds while the decode stage stalls
  stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (md_sel_i && ex_valid_i && !ready_i) |=> (ex_valid_i && $stable(result_i)))
    else begin
      fail_count++;
      $error("ex_valid_o or result_ex_o changed under back-pressure");
    end

  imd_write_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !md_sel_i |-> !imd_val_we_i)
    else begin
      fail_count++;
      $error("Intermediate register written with md_sel_i low");
    end

endmodule

bind ex_block ex_block_assertions u_assertions (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .md_sel_i     (md_sel_i),
  .ready_i      (multdiv_ready_id_i),
  .ex_valid_i   (ex_valid_o),
  .result_i     (result_ex_o),
  .imd_val_we_i (imd_val_we)
);

/* bench/tb_ex_block.sv */
// Directed testbench for the execute stage
// Clock, reset, LFSR stimulus, reference model and compare tasks
// ALU, multiply, divide and back-pressure tests

`timescale 1ns/100ps

module tb_ex_block;
  import ex_pkg::*;

  localparam int          CLK_PERIOD     = 20;
  localparam int          DRIVE_DELAY    = 2;
  localparam int          RESET_CYCLES   = 16;
  localparam int          MD_MAX_CYCLES  = 40;
  localparam int          TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] LFSR_SEED      = 32'h6521_7564;

  logic            clk_i;
  logic            rst_n_i;
  alu_op_e         alu_operator_i;
  logic [XLEN-1:0] alu_operand_a_i;
  logic [XLEN-1:0] alu_operand_b_i;
  logic [XLEN-1:0] bt_a_operand_i;
  logic [XLEN-1:0] bt_b_operand_i;
  md_op_e          multdiv_operator_i;
  logic            md_en_i;
  logic            md_sel_i;
  logic [XLEN-1:0] multdiv_operand_a_i;
  logic [XLEN-1:0] multdiv_operand_b_i;
  logic            multdiv_ready_id_i;
  logic [XLEN-1:0] alu_adder_result_ex_o;
  logic [XLEN-1:0] result_ex_o;
  logic [XLEN-1:0] branch_target_o;
  logic            branch_decision_o;
  logic            ex_valid_o;

  logic [31:0] lfsr_state  = LFSR_SEED;
  int unsigned cycle_count = 0;

  ex_block #(
    .RV32M           (1'b1),
    .BranchTargetALU (1'b1)
  ) dut0 (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .alu_operator_i        (alu_operator_i),
    .alu_operand_a_i       (alu_operand_a_i),
    .alu_operand_b_i       (alu_operand_b_i),
    .bt_a_operand_i        (bt_a_operand_i),
    .bt_b_operand_i        (bt_b_operand_i),
    .multdiv_operator_i    (multdiv_operator_i),
    .md_en_i               (md_en_i),
    .md_sel_i              (md_sel_i),
    .multdiv_operand_a_i   (multdiv_operand_a_i),
    .multdiv_operand_b_i   (multdiv_operand_b_i),
    .multdiv_ready_id_i    (multdiv_ready_id_i),
    .alu_adder_result_ex_o (alu_adder_result_ex_o),
    .result_ex_o           (result_ex_o),
    .branch_target_o       (branch_target_o),
    .branch_decision_o     (branch_decision_o),
    .ex_valid_o            (ex_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Failure handling
  ////////////////////

  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count == TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  always @(negedge clk_i) begin
    if (dut0.u_assertions.fail_count != 0) begin
      fail_run("A concurrent assertion on ex_block failed");
    end
  end

  ////////////////////
  // Stimulus and model
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(int unsigned n);
    logic [31:0] bits;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits       = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic logic branch_ref(alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    sa = a;
    sb = b;
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return sa < sb;
      ALU_GE:            return sa >= sb;
      ALU_LTU, ALU_SLTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(alu_op_e op, logic [XLEN-1:0] a,
                                              logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    sa = a;
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_XOR: return a ^ b;
      ALU_OR:  return a | b;
      ALU_AND: return a & b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return sa >>> b[4:0];
      default: return {{(XLEN-1){1'b0}}, branch_ref(op, a, b)};
    endcase
  endfunction

  // Subtract for SUB and every comparison, add otherwise
  function automatic logic [XLEN-1:0] adder_sum_ref(alu_op_e op, logic [XLEN-1:0] a,
                                                    logic [XLEN-1:0] b);
    if (op inside {ALU_ADD, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA}) begin
      return a + b;
    end
    return a - b;
  endfunction

  function automatic logic [XLEN-1:0] md_ref(md_op_e op, logic [XLEN-1:0] a,
                                             logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] wa_s;
    logic signed [2*XLEN-1:0] wb_s;
    logic signed [2*XLEN-1:0] wb_u;
    logic [2*XLEN-1:0]        prod;
    logic signed [XLEN-1:0]   sa;
    logic signed [XLEN-1:0]   sb;
    logic signed [XLEN-1:0]   quot_s;
    logic signed [XLEN-1:0]   rem_s;
    logic                     overflow;
    logic                     div_zero;
    wa_s     = {{XLEN{a[XLEN-1]}}, a};
    wb_s     = {{XLEN{b[XLEN-1]}}, b};
    wb_u     = {{XLEN{1'b0}}, b};
    sa       = a;
    sb       = b;
    div_zero = (b == '0);
    overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    quot_s   = '0;
    rem_s    = '0;
    // Truncating signed quotient and remainder
    if (!div_zero && !overflow) begin
      quot_s = sa / sb;
      rem_s  = sa % sb;
    end
    case (op)
      MD_MUL: begin
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        return prod[XLEN-1:0];
      end
      MD_MULH: begin
        prod = wa_s * wb_s;
        return prod[2*XLEN-1:XLEN];
      end
      MD_MULHSU: begin
        prod = wa_s * wb_u;
        return prod[2*XLEN-1:XLEN];
      end
      MD_MULHU: begin
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        return prod[2*XLEN-1:XLEN];
      end
      MD_DIV:  return div_zero ? '1 : (overflow ? a : quot_s);
      MD_DIVU: return div_zero ? '1 : a / b;
      MD_REM:  return div_zero ? a : (overflow ? '0 : rem_s);
      default: return div_zero ? a : a % b;
    endcase
  endfunction

  ////////////////////
  // Operation drivers
  ////////////////////

  task automatic run_alu(alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic [XLEN-1:0] bt_a;
    logic [XLEN-1:0] bt_b;
    bt_a = take_bits(32);
    bt_b = take_bits(32);
    @(posedge clk_i);
    #DRIVE_DELAY;
    alu_operator_i  = op;
    alu_operand_a_i = a;
    alu_operand_b_i = b;
    bt_a_operand_i  = bt_a;
    bt_b_operand_i  = bt_b;
    @(negedge clk_i);
    check_bit("ex_valid_o", ex_valid_o, 1'b1);
    check_word($sformatf("result_ex_o (%s)", op.name()), result_ex_o, alu_ref(op, a, b));
    check_word($sformatf("alu_adder_result_ex_o (%s)", op.name()), alu_adder_result_ex_o,
               adder_sum_ref(op, a, b));
    check_word("branch_target_o", branch_target_o, bt_a + bt_b);
    if (op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU}) begin
      check_bit($sformatf("branch_decision_o (%s)", op.name()), branch_decision_o,
                branch_ref(op, a, b));
    end
  endtask

  // Stall counts extra cycles with ready low once the result is valid
  task automatic run_md(md_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                        int unsigned stall);
    logic [XLEN-1:0] held;
    int unsigned     cycles;
    @(posedge clk_i);
    #DRIVE_DELAY;
    multdiv_operator_i  = op;
    multdiv_operand_a_i = a;
    multdiv_operand_b_i = b;
    md_sel_i            = 1'b1;
    md_en_i             = 1'b1;
    multdiv_ready_id_i  = (stall == 0);
    @(negedge clk_i);
    check_bit("ex_valid_o in first cycle", ex_valid_o, 1'b0);
    cycles = 0;
    while (ex_valid_o !== 1'b1) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > MD_MAX_CYCLES) begin
        fail_run($sformatf("%s of %h and %h never raised ex_valid_o", op.name(), a, b));
      end
    end
    check_word($sformatf("result_ex_o (%s %h, %h)", op.name(), a, b), result_ex_o,
               md_ref(op, a, b));
    held = result_ex_o;
    repeat (stall) begin
      @(negedge clk_i);
      check_bit("ex_valid_o under back-pressure", ex_valid_o, 1'b1);
      check_word("result_ex_o under back-pressure", result_ex_o, held);
    end
    if (stall != 0) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      multdiv_ready_id_i = 1'b1;
    end
    // Handshake edge, then release the unit
    @(posedge clk_i);
    #DRIVE_DELAY;
    md_en_i  = 1'b0;
    md_sel_i = 1'b0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_valid_check();
    @(negedge clk_i);
    check_bit("ex_valid_o after reset", ex_valid_o, 1'b1);
    run_md(MD_MUL, 32'd3, 32'd5, 0);
  endtask

  task automatic alu_sweep();
    logic [XLEN-1:0] corners [4];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    alu_op_e         op;
    corners = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_001F};
    for (int i = 0; i < 16; i++) begin
      op = alu_op_e'(i[3:0]);
      foreach (corners[j]) begin
        foreach (corners[k]) begin
          run_alu(op, corners[j], corners[k]);
        end
      end
      repeat (6) begin
        a = take_bits(32);
        b = take_bits(32);
        run_alu(op, a, b);
      end
    end
  endtask

  task automatic multiply_tests();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    md_op_e          op;
    for (int i = 0; i < 4; i++) begin
      op = md_op_e'(i[2:0]);
      run_md(op, 32'h8000_0000, 32'hFFFF_FFFF, 0);
      run_md(op, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
      run_md(op, 32'h8000_0000, 32'h8000_0000, 0);
      run_md(op, 32'h0000_0000, 32'h1234_5678, 0);
      repeat (6) begin
        a = take_bits(32);
        b = take_bits(32);
        run_md(op, a, b, 0);
      end
    end
  endtask

  task automatic divide_tests();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    md_op_e          op;
    for (int i = 4; i < 8; i++) begin
      op = md_op_e'(i[2:0]);
      // Zero divisor, then the signed overflow case
      run_md(op, 32'hDEAD_BEEF, 32'h0000_0000, 0);
      run_md(op, 32'h8000_0000, 32'hFFFF_FFFF, 0);
      run_md(op, 32'hFFFF_FFF9, 32'h0000_0002, 0);
      run_md(op, 32'h0000_0007, 32'hFFFF_FFFE, 0);
      repeat (4) begin
        a = take_bits(32);
        b = take_bits(32);
        run_md(op, a, b, 0);
        b = take_bits(8);
        run_md(op, a, b, 0);
      end
    end
  endtask

  task automatic backpressure_tests();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [2:0]      code;
    int unsigned     stall;
    repeat (6) begin
      code  = take_bits(3);
      a     = take_bits(32);
      b     = take_bits(32);
      stall = (take_bits(4) % 10) + 1;
      run_md(md_op_e'(code), a, b, stall);
      // Next operation must start from a clean state
      code = take_bits(3);
      a    = take_bits(32);
      b    = take_bits(32);
      run_md(md_op_e'(code), a, b, 0);
    end
  endtask

  initial begin
    rst_n_i             = 1'b0;
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    bt_a_operand_i      = '0;
    bt_b_operand_i      = '0;
    multdiv_operator_i  = MD_MUL;
    md_en_i             = 1'b0;
    md_sel_i            = 1'b0;
    multdiv_operand_a_i = '0;
    multdiv_operand_b_i = '0;
    multdiv_ready_id_i  = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;

    reset_valid_check();
    alu_sweep();
    multiply_tests();
    divide_tests();
    backpressure_tests();
    repeat (4) @(posedge clk_i);

    if (dut0.u_assertions.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      fail_run("A concurrent assertion on ex_block failed");
    end
  end

endmodule

/* compile.f */
rtl/ex_pkg.sv
rtl/alu_share_if.sv
rtl/ex_alu.sv
rtl/ex_multdiv_slow.sv
rtl/ex_block.sv
bench/ex_block_assertions.sv
bench/tb_ex_block.sv

/* rtl/alu_share_if.sv */
// ALU adder sharing bus
// Operands and select toward the ALU, sum and zero flag back

`timescale 1ns/100ps

interface alu_share_if
  import ex_pkg::*;
();

  // Operands carry a carry-in bit in the LSB
  logic [XLEN:0]    operand_a;
  logic [XLEN:0]    operand_b;
  logic             sel;
  logic [IMD_W-1:0] adder_ext;
  logic [XLEN-1:0]  adder;
  logic             is_equal;

  modport alu (
    input  operand_a, operand_b, sel,
    output adder_ext, adder, is_equal
  );

  modport md (
    output operand_a, operand_b,
    input  adder_ext, adder, is_equal
  );

endinterface

/* rtl/ex_alu.sv */
// Single-cycle integer ALU
// Adder shared with the mult/div unit, shifter, logic ops, comparisons

`timescale 1ns/100ps

module ex_alu
  import ex_pkg::*;
(
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  alu_share_if.alu        share,
  output logic [XLEN-1:0] adder_result_o,
  output logic [XLEN-1:0] result_o,
  output logic            comparison_result_o,
  output logic            is_equal_result_o
);

  logic             adder_negate;
  logic [XLEN:0]    operand_b_neg;
  logic [XLEN:0]    adder_in_a;
  logic [XLEN:0]    adder_in_b;
  logic [IMD_W-1:0] adder_ext;
  logic [XLEN-1:0]  adder_result;
  logic             is_equal;
  logic             cmp_signed;
  logic             is_greater_equal;
  logic             shift_left;
  logic             shift_arith;
  logic [XLEN-1:0]  operand_a_rev;
  logic [XLEN-1:0]  shift_operand;
  logic [XLEN:0]    shift_right_ext;
  logic [XLEN-1:0]  shift_right;
  logic [XLEN-1:0]  shift_right_rev;
  logic [XLEN-1:0]  shift_result;

  ////////////////////
  // Adder
  ////////////////////

  assign adder_negate = operator_i inside {ALU_SUB, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
                                           ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};

  // LSB of each operand is a carry-in; both set gives a + ~b + 1
  assign operand_b_neg = {operand_b_i, 1'b0} ^ {(XLEN+1){adder_negate}};

  assign adder_in_a   = share.sel ? share.operand_a : {operand_a_i, 1'b1};
  assign adder_in_b   = share.sel ? share.operand_b : operand_b_neg;
  assign adder_ext    = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_result = adder_ext[XLEN:1];

  // Zero sum, so equal operands on a subtract
  assign is_equal = (adder_result == '0);

  assign share.adder_ext = adder_ext;
  assign share.adder     = adder_result;
  assign share.is_equal  = is_equal;

  ////////////////////
  // Comparisons
  ////////////////////

  assign cmp_signed = operator_i inside {ALU_SLT, ALU_LT, ALU_GE};

  // Differing MSBs decide directly, else the sign of a - b
  always_comb begin
    if (operand_a_i[XLEN-1] ^ operand_b_i[XLEN-1]) begin
      is_greater_equal = operand_a_i[XLEN-1] ^ cmp_signed;
    end else begin
      is_greater_equal = ~adder_result[XLEN-1];
    end
  end

  always_comb begin
    unique case (operator_i)
      ALU_EQ:                  comparison_result_o = is_equal;
      ALU_NE:                  comparison_result_o = ~is_equal;
      ALU_GE, ALU_GEU:         comparison_result_o = is_greater_equal;
      default:                 comparison_result_o = ~is_greater_equal;
    endcase
  end

  ////////////////////
  // Shifter
  ////////////////////

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);

  // Left shift as a right shift of the reversed word
  assign operand_a_rev   = {<<{operand_a_i}};
  assign shift_operand   = shift_left ? operand_a_rev : operand_a_i;
  assign shift_right_ext = $signed({shift_arith & operand_a_i[XLEN-1], shift_operand})
                           >>> operand_b_i[4:0];
  assign shift_right     = shift_right_ext[XLEN-1:0];
  assign shift_right_rev = {<<{shift_right}};
  assign shift_result    = shift_left ? shift_right_rev : shift_right;

  // Result select
  always_comb begin
    unique case (operator_i)
      ALU_ADD, ALU_SUB:          result_o = adder_result;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      default:                   result_o = {{(XLEN-1){1'b0}}, comparison_result_o};
    endcase
  end

  assign adder_result_o    = adder_result;
  assign is_equal_result_o = is_equal;

endmodule

/* rtl/ex_block.sv */
// Execute stage top
// ALU, mult/div unit, intermediate value register, branch target adder
// and the result and valid muxes

`timescale 1ns/100ps

module ex_block
  import ex_pkg::*;
#(
  parameter bit RV32M           = 1'b1,
  parameter bit BranchTargetALU = 1'b0
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  alu_op_e         alu_operator_i,
  input  logic [XLEN-1:0] alu_operand_a_i,
  input  logic [XLEN-1:0] alu_operand_b_i,
  input  logic [XLEN-1:0] bt_a_operand_i,
  input  logic [XLEN-1:0] bt_b_operand_i,
  input  md_op_e          multdiv_operator_i,
  input  logic            md_en_i,
  input  logic            md_sel_i,
  input  logic [XLEN-1:0] multdiv_operand_a_i,
  input  logic [XLEN-1:0] multdiv_operand_b_i,
  input  logic            multdiv_ready_id_i,
  output logic [XLEN-1:0] alu_adder_result_ex_o,
  output logic [XLEN-1:0] result_ex_o,
  output logic [XLEN-1:0] branch_target_o,
  output logic            branch_decision_o,
  output logic            ex_valid_o
);

  logic [XLEN-1:0]  alu_result;
  logic             alu_cmp_result;
  logic             multdiv_sel;
  logic             multdiv_valid;
  logic [XLEN-1:0]  multdiv_result;
  logic [IMD_W-1:0] multdiv_imd_val_d;
  logic             multdiv_imd_val_we;
  logic             imd_val_we;
  logic [IMD_W-1:0] imd_val_q;

  alu_share_if share_bus ();

  assign share_bus.sel = multdiv_sel;

  ex_alu u_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .share               (share_bus),
    .adder_result_o      (alu_adder_result_ex_o),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result),
    .is_equal_result_o   ()
  );

  // Without RV32M the unit is never selected and drops out
  if (RV32M) begin : g_multdiv
    logic multdiv_en;

    assign multdiv_sel = md_sel_i;
    assign multdiv_en  = md_en_i & md_sel_i;

    ex_multdiv_slow u_multdiv (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .en_i         (multdiv_en),
      .operator_i   (multdiv_operator_i),
      .op_a_i       (multdiv_operand_a_i),
      .op_b_i       (multdiv_operand_b_i),
      .imd_val_q_i  (imd_val_q),
      .ready_i      (multdiv_ready_id_i),
      .share        (share_bus),
      .imd_val_d_o  (multdiv_imd_val_d),
      .imd_val_we_o (multdiv_imd_val_we),
      .valid_o      (multdiv_valid),
      .result_o     (multdiv_result)
    );
  end else begin : g_no_multdiv
    assign multdiv_sel         = 1'b0;
    assign multdiv_valid       = 1'b0;
    assign multdiv_result      = '0;
    assign multdiv_imd_val_d   = '0;
    assign multdiv_imd_val_we  = 1'b0;
    assign share_bus.operand_a = '0;
    assign share_bus.operand_b = '0;
  end

  ////////////////////
  // Intermediate value
  ////////////////////

  // Only the mult/div unit writes it
  assign imd_val_we = multdiv_sel & multdiv_imd_val_we;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      imd_val_q <= '0;
    end else if (imd_val_we) begin
      imd_val_q <= multdiv_imd_val_d;
    end
  end

  // Result and valid select
  assign result_ex_o       = multdiv_sel ? multdiv_result : alu_result;
  assign ex_valid_o        = multdiv_sel ? multdiv_valid : 1'b1;
  assign branch_decision_o = alu_cmp_result;

  if (BranchTargetALU) begin : g_bt_adder
    // Wraps to 32 bits
    assign branch_target_o = bt_a_operand_i + bt_b_operand_i;
  end else begin : g_no_bt_adder
    assign branch_target_o = alu_adder_result_ex_o;
  end

endmodule

/* rtl/ex_multdiv_slow.sv */
// Iterative multiplier/divider for the M extension
// Shift-and-add multiply and restoring divide on operand magnitudes,
// all additions done by the shared ALU adder

`timescale 1ns/100ps

module ex_multdiv_slow
  import ex_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             en_i,
  input  md_op_e           operator_i,
  input  logic [XLEN-1:0]  op_a_i,
  input  logic [XLEN-1:0]  op_b_i,
  input  logic [IMD_W-1:0] imd_val_q_i,
  input  logic             ready_i,
  alu_share_if.md          share,
  output logic [IMD_W-1:0] imd_val_d_o,
  output logic             imd_val_we_o,
  output logic             valid_o,
  output logic [XLEN-1:0]  result_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ABS_A,
    ST_ABS_B,
    ST_COMP,
    ST_LAST,
    ST_CHANGE_SIGN,
    ST_FINISH
  } md_state_e;

  md_state_e       state_q, state_d;
  logic [4:0]      count_q, count_d;
  logic            div_zero_q, div_zero_d;
  logic [XLEN-1:0] op_a_shift_q, op_a_shift_d;
  logic [XLEN-1:0] op_b_q, op_b_d;
  logic [XLEN-1:0] accum_q;
  logic            is_div;
  logic            signed_a, signed_b;
  logic            sign_a, sign_b;
  logic            result_in_shift;
  logic            neg_result;
  logic            fix_carry;
  logic [XLEN-1:0] div_shifted;
  logic            div_ge;
  logic [XLEN-1:0] accum_next, shift_next;

  // Accumulator, remainder, then the final result
  assign accum_q = imd_val_q_i[XLEN-1:0];

  ////////////////////
  // Operator decode
  ////////////////////

  assign is_div          = operator_i inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU};
  assign signed_a        = operator_i inside {MD_MULH, MD_MULHSU, MD_DIV, MD_REM};
  assign signed_b        = operator_i inside {MD_MULH, MD_DIV, MD_REM};
  assign sign_a          = signed_a & op_a_i[XLEN-1];
  assign sign_b          = signed_b & op_b_i[XLEN-1];
  assign result_in_shift = operator_i inside {MD_MUL, MD_DIV, MD_DIVU};

  // Remainder follows the dividend; no quotient fix on a zero divisor
  always_comb begin
    unique case (operator_i)
      MD_MULH, MD_MULHSU: neg_result = sign_a ^ sign_b;
      MD_DIV:             neg_result = (sign_a ^ sign_b) & ~div_zero_q;
      MD_REM:             neg_result = sign_a;
      default:            neg_result = 1'b0;
    endcase
  end

  // High word of -P is ~hi, plus one only if the low word is zero
  assign fix_carry = (operator_i inside {MD_MULH, MD_MULHSU}) ? (op_a_shift_q == '0) : 1'b1;

  ////////////////////
  // Iteration step
  ////////////////////

  // Trial subtract; MSB of the remainder covers the 33rd bit
  assign div_shifted = {accum_q[XLEN-2:0], op_a_shift_q[XLEN-1]};
  assign div_ge      = accum_q[XLEN-1] | share.adder_ext[IMD_W-1];

  always_comb begin
    if (is_div) begin
      accum_next = div_ge ? share.adder : div_shifted;
      shift_next = {op_a_shift_q[XLEN-2:0], div_ge};
    end else begin
      accum_next = share.adder_ext[IMD_W-1:2];
      shift_next = {share.adder_ext[1], op_a_shift_q[XLEN-1:1]};
    end
  end

  // Adder operands; default is 0 - B for the zero divisor check
  always_comb begin
    share.operand_a = {{XLEN{1'b0}}, 1'b1};
    share.operand_b = {~op_b_i, 1'b1};
    unique case (state_q)
      ST_ABS_A: begin
        share.operand_b = {~op_a_i, 1'b1};
      end
      ST_COMP, ST_LAST: begin
        if (is_div) begin
          share.operand_a = {div_shifted, 1'b1};
          share.operand_b = {~op_b_q, 1'b1};
        end else begin
          share.operand_a = {accum_q, 1'b0};
          share.operand_b = {op_b_q & {XLEN{op_a_shift_q[0]}}, 1'b0};
        end
      end
      ST_CHANGE_SIGN: begin
        share.operand_a = {{XLEN{1'b0}}, fix_carry};
        share.operand_b = {~accum_q, fix_carry};
      end
      default: ;
    endcase
  end

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d      = state_q;
    count_d      = count_q;
    div_zero_d   = div_zero_q;
    op_a_shift_d = op_a_shift_q;
    op_b_d       = op_b_q;
    imd_val_d_o  = {{(IMD_W-XLEN){1'b0}}, accum_next};
    imd_val_we_o = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        if (en_i) begin
          div_zero_d   = share.is_equal;
          imd_val_d_o  = '0;
          imd_val_we_o = 1'b1;
          state_d      = ST_ABS_A;
        end
      end
      ST_ABS_A: begin
        op_a_shift_d = sign_a ? share.adder : op_a_i;
        state_d      = ST_ABS_B;
      end
      ST_ABS_B: begin
        op_b_d  = sign_b ? share.adder : op_b_i;
        count_d = 5'd31;
        state_d = ST_COMP;
      end
      ST_COMP: begin
        op_a_shift_d = shift_next;
        imd_val_we_o = 1'b1;
        count_d      = count_q - 5'd1;
        if (count_q == 5'd1) begin
          state_d = ST_LAST;
        end
      end
      ST_LAST: begin
        // Move the answer into the intermediate register
        op_a_shift_d = shift_next;
        if (result_in_shift) begin
          imd_val_d_o = {{(IMD_W-XLEN){1'b0}}, shift_next};
        end
        imd_val_we_o = 1'b1;
        state_d      = ST_CHANGE_SIGN;
      end
      ST_CHANGE_SIGN: begin
        imd_val_d_o  = {{(IMD_W-XLEN){1'b0}}, share.adder};
        imd_val_we_o = neg_result;
        state_d      = ST_FINISH;
      end
      ST_FINISH: begin
        if (ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      count_q    <= '0;
      div_zero_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      count_q    <= count_d;
      div_zero_q <= div_zero_d;
    end
  end

  always_ff @(posedge clk_i) begin
    op_a_shift_q <= op_a_shift_d;
    op_b_q       <= op_b_d;
  end

  assign valid_o  = (state_q == ST_FINISH);
  assign result_o = accum_q;

endmodule

/* rtl/ex_pkg.sv */
// Execute stage definitions
// ALU and multiplier/divider operator encodings, data widths

package ex_pkg;

  // Data path width
  localparam int unsigned XLEN  = 32;

  // Intermediate value, one word plus two extension bits
  localparam int unsigned IMD_W = XLEN + 2;

  ////////////////////
  // ALU operators
  ////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    // Branch comparisons
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  ////////////////////
  // Mult/div operators
  ////////////////////

  typedef enum logic [2:0] {
    MD_MUL,
    MD_MULH,
    MD_MULHSU,
    MD_MULHU,
    MD_DIV,
    MD_DIVU,
    MD_REM,
    MD_REMU
  } md_op_e;

endpackage
